/* src/cpu_pkg.sv */
// shared types and sizes for the rv32i subset core; memories are word indexed, 64 words each
package cpu_pkg;

  localparam int xlen = 32;  // data and address width
  localparam int reg_idx_w = 5;  // 32 architectural registers
  localparam int imem_depth = 64;  // instruction words
  localparam int dmem_depth = 64;  // data words
  localparam int imem_addr_w = 6;  // program-load address width, log2 of imem_depth

  localparam logic [reg_idx_w-1:0] halt_reg = 5'd17;  // a7 holds the ecall code
  localparam logic [xlen-1:0] halt_code = 32'd10;  // exit code
  localparam logic [xlen-1:0] reset_pc = 32'd0;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,  // add sub and or xor slt
    opc_op_imm = 7'b0010011,  // addi only
    opc_load   = 7'b0000011,  // lw
    opc_store  = 7'b0100011,  // sw
    opc_branch = 7'b1100011,  // beq bne
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011   // ecall
  } opcode_e;

  // zero must stay add, a bubble decodes to it
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5   // signed compare
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;  // load data goes to rd
    logic    alu_src;  // imm as second operand
    logic    branch;  // beq or bne, sense in funct3[0]
    logic    jump;  // jal
    logic    ecall;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t                ctrl;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      imm;
    logic [reg_idx_w-1:0] rs1;  // halt_reg for ecall
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    logic [2:0]           funct3;
  } id_ex_t;

  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;
    logic                 halt;  // the halting ecall
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      alu_out;  // also the data address, or pc+4 for jal
    logic [xlen-1:0]      store_data;
  } ex_mem_t;

  // mem/wb register, already past the writeback select
  typedef struct packed {
    logic                 reg_write;
    logic                 halt;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      data;
  } wb_t;

endpackage

/* src/fetch_stage.sv */
// fetch with always-not-taken; imem is not reset and must be loaded through prog_* before use
`timescale 1ns/1ns

module fetch_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               prog_we,
  input  logic [cpu_pkg::imem_addr_w-1:0]    prog_addr,
  input  logic [cpu_pkg::xlen-1:0]           prog_data,
  input  logic                               stall,
  input  logic                               redirect,
  input  logic [cpu_pkg::xlen-1:0]           redirect_pc,
  input  logic                               halt_seen,
  output cpu_pkg::if_id_t                    if_id
);

  logic [cpu_pkg::xlen-1:0] pc;
  logic [cpu_pkg::xlen-1:0] imem [cpu_pkg::imem_depth];
  logic [cpu_pkg::xlen-1:0] inst;

  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;  // loads also while in reset
    end
  end

  assign inst = imem[pc[cpu_pkg::imem_addr_w+1:2]];  // word index, async read

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= cpu_pkg::reset_pc;
    end else if (halt_seen) begin
      pc <= pc;  // frozen for good once ecall halts
    end else if (redirect) begin
      pc <= redirect_pc;  // taken branch or jal from execute
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect || halt_seen) begin
      if_id.valid <= 1'b0;  // flush slot, payload left stale
    end else if (!stall) begin
      if_id <= '{valid: 1'b1, pc: pc, inst: inst};
    end
  end

endmodule

/* src/decode_stage.sv */
// decode, register file and load-use stall; x0 reads zero, writes from wb pass through same cycle
`timescale 1ns/1ns

module decode_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_pkg::if_id_t                    if_id,
  input  logic                               redirect,
  input  cpu_pkg::wb_t                       wb,
  input  logic [cpu_pkg::reg_idx_w-1:0]      dbg_idx,
  output logic [cpu_pkg::xlen-1:0]           dbg_data,
  output logic                               stall,
  output cpu_pkg::id_ex_t                    id_ex
);

  logic [cpu_pkg::xlen-1:0] rf [2**cpu_pkg::reg_idx_w];
  cpu_pkg::opcode_e opcode;
  cpu_pkg::ctrl_t ctrl;
  logic [cpu_pkg::xlen-1:0] inst;
  logic [cpu_pkg::xlen-1:0] imm;
  logic [cpu_pkg::reg_idx_w-1:0] rs1_idx;
  logic uses_rs1;
  logic uses_rs2;
  cpu_pkg::id_ex_t id_ex_d;

  // read with write-through from the writeback bundle
  function automatic logic [cpu_pkg::xlen-1:0] rf_read(input logic [cpu_pkg::reg_idx_w-1:0] idx);
    if (idx == '0) begin
      return '0;
    end else if (wb.reg_write && wb.rd == idx) begin
      return wb.data;
    end
    return rf[idx];
  endfunction

  assign inst = if_id.inst;
  assign opcode = cpu_pkg::opcode_e'(inst[6:0]);

  always_comb begin
    ctrl = '0;  // unknown opcodes run as nop
    imm = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      cpu_pkg::opc_op: begin
        ctrl.reg_write = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (inst[14:12])
          3'b000: ctrl.alu_op = inst[30] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
          3'b111: ctrl.alu_op = cpu_pkg::alu_and;
          3'b110: ctrl.alu_op = cpu_pkg::alu_or;
          3'b100: ctrl.alu_op = cpu_pkg::alu_xor;
          3'b010: ctrl.alu_op = cpu_pkg::alu_slt;
          default: ctrl.reg_write = 1'b0;  // unsupported funct3, drop
        endcase
      end
      cpu_pkg::opc_op_imm: begin
        ctrl.reg_write = 1'b1;  // addi, add by default
        ctrl.alu_src = 1'b1;
        uses_rs1 = 1'b1;
        imm = {{20{inst[31]}}, inst[31:20]};  // I
      end
      cpu_pkg::opc_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src = 1'b1;
        uses_rs1 = 1'b1;
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      cpu_pkg::opc_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;  // store data
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};  // S
      end
      cpu_pkg::opc_branch: begin
        ctrl.branch = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};  // B
      end
      cpu_pkg::opc_jal: begin
        ctrl.reg_write = 1'b1;  // link
        ctrl.jump = 1'b1;
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};  // J
      end
      cpu_pkg::opc_system: begin
        ctrl.ecall = 1'b1;  // imm 0, so a halt redirects to itself
        uses_rs1 = 1'b1;
      end
      default: ;
    endcase
    if (!if_id.valid) begin
      ctrl = '0;  // flushed slot
    end
  end

  assign rs1_idx = ctrl.ecall ? cpu_pkg::halt_reg : inst[19:15];  // ecall inspects x17

  // load in ex whose rd is a live source here
  assign stall = if_id.valid && id_ex.ctrl.mem_read && id_ex.rd != '0
                 && ((uses_rs1 && id_ex.rd == rs1_idx) || (uses_rs2 && id_ex.rd == inst[24:20]));

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**cpu_pkg::reg_idx_w; i++) begin
        rf[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != '0) begin
      rf[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    id_ex_d.ctrl = ctrl;
    id_ex_d.pc = if_id.pc;
    id_ex_d.rs1_data = rf_read(rs1_idx);
    id_ex_d.rs2_data = rf_read(inst[24:20]);
    id_ex_d.imm = imm;
    id_ex_d.rs1 = rs1_idx;
    id_ex_d.rs2 = inst[24:20];
    id_ex_d.rd = inst[11:7];
    id_ex_d.funct3 = inst[14:12];
    dbg_data = rf_read(dbg_idx);  // debug port, same bypass
  end

  always_ff @(posedge clk) begin
    id_ex <= id_ex_d;
    if (reset || stall || redirect) begin
      id_ex.ctrl <= '0;  // bubble
    end
  end

endmodule

/* src/execute_stage.sv */
// execute with forwarding; branches, jal and the halting ecall resolve here and flush two slots
`timescale 1ns/1ns

module execute_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_pkg::id_ex_t             id_ex,
  input  cpu_pkg::wb_t                wb,
  output logic                        redirect,
  output logic [cpu_pkg::xlen-1:0]    redirect_pc,
  output logic                        halt_seen,
  output cpu_pkg::ex_mem_t            ex_mem
);

  logic [cpu_pkg::xlen-1:0] fwd_a;
  logic [cpu_pkg::xlen-1:0] fwd_b;
  logic [cpu_pkg::xlen-1:0] alu_b;
  logic [cpu_pkg::xlen-1:0] alu_y;
  logic taken;
  logic halt_now;
  logic halt_q;

  // newest writer wins, x0 never forwarded
  function automatic logic [cpu_pkg::xlen-1:0] forward(
    input logic [cpu_pkg::reg_idx_w-1:0] idx,
    input logic [cpu_pkg::xlen-1:0]      rf_val,
    input cpu_pkg::ex_mem_t              em,
    input cpu_pkg::wb_t                  w
  );
    if (idx != '0 && em.reg_write && em.rd == idx) begin
      return em.alu_out;  // never a load, the stall keeps it away
    end else if (idx != '0 && w.reg_write && w.rd == idx) begin
      return w.data;
    end
    return rf_val;
  endfunction

  assign fwd_a = forward(id_ex.rs1, id_ex.rs1_data, ex_mem, wb);
  assign fwd_b = forward(id_ex.rs2, id_ex.rs2_data, ex_mem, wb);
  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      cpu_pkg::alu_sub: alu_y = fwd_a - alu_b;
      cpu_pkg::alu_and: alu_y = fwd_a & alu_b;
      cpu_pkg::alu_or:  alu_y = fwd_a | alu_b;
      cpu_pkg::alu_xor: alu_y = fwd_a ^ alu_b;
      cpu_pkg::alu_slt: alu_y = {31'd0, $signed(fwd_a) < $signed(alu_b)};
      default:          alu_y = fwd_a + alu_b;
    endcase
  end

  // funct3[0] picks bne over beq
  assign taken = id_ex.ctrl.branch && ((fwd_a == fwd_b) ^ id_ex.funct3[0]);
  assign halt_now = id_ex.ctrl.ecall && fwd_a == cpu_pkg::halt_code;
  assign redirect = id_ex.ctrl.jump || taken || halt_now;
  assign redirect_pc = id_ex.pc + id_ex.imm;  // ecall imm is 0

  always_ff @(posedge clk) begin
    if (reset) begin
      halt_q <= 1'b0;
    end else if (halt_now) begin
      halt_q <= 1'b1;  // sticky until reset
    end
  end

  assign halt_seen = halt_now || halt_q;

  always_ff @(posedge clk) begin
    ex_mem.rd <= id_ex.rd;
    ex_mem.alu_out <= id_ex.ctrl.jump ? id_ex.pc + 32'd4 : alu_y;  // jal links pc+4
    ex_mem.store_data <= fwd_b;
    if (reset) begin
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.halt <= 1'b0;
    end else begin
      ex_mem.reg_write <= id_ex.ctrl.reg_write;
      ex_mem.mem_read <= id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.halt <= halt_now;
    end
  end

endmodule

/* src/memory_stage.sv */
// word-addressed data memory, cleared on reset; address bits above the depth wrap around
`timescale 1ns/1ns

module memory_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::ex_mem_t   ex_mem,
  output cpu_pkg::wb_t       wb
);

  logic [cpu_pkg::xlen-1:0] dmem [cpu_pkg::dmem_depth];
  logic [$clog2(cpu_pkg::dmem_depth)-1:0] dmem_addr;
  logic [cpu_pkg::xlen-1:0] load_data;

  assign dmem_addr = ex_mem.alu_out[$clog2(cpu_pkg::dmem_depth)+1:2];  // byte to word
  assign load_data = ex_mem.mem_read ? dmem[dmem_addr] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::dmem_depth; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  // mem/wb register with the writeback select folded in
  always_ff @(posedge clk) begin
    wb.rd <= ex_mem.rd;
    wb.data <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_out;
    if (reset) begin
      wb.reg_write <= 1'b0;
      wb.halt <= 1'b0;
    end else begin
      wb.reg_write <= ex_mem.reg_write;
      wb.halt <= ex_mem.halt;
    end
  end

endmodule

/* src/cpu.sv */
// five-stage rv32i subset core, no handshakes; load a program through prog_* before releasing reset
`timescale 1ns/1ns

module cpu (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               prog_we,
  input  logic [cpu_pkg::imem_addr_w-1:0]    prog_addr,
  input  logic [cpu_pkg::xlen-1:0]           prog_data,
  input  logic [cpu_pkg::reg_idx_w-1:0]      dbg_idx,
  output logic                               is_halted,
  output logic [cpu_pkg::xlen-1:0]           dbg_data
);

  cpu_pkg::if_id_t if_id;
  cpu_pkg::id_ex_t id_ex;
  cpu_pkg::ex_mem_t ex_mem;
  cpu_pkg::wb_t wb;  // selected writeback, fed back to decode and execute
  logic stall;
  logic redirect;
  logic [cpu_pkg::xlen-1:0] redirect_pc;
  logic halt_seen;

  fetch_stage u_fetch (
    .clk(clk), .reset(reset),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
    .halt_seen(halt_seen), .if_id(if_id)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .if_id(if_id), .redirect(redirect), .wb(wb),
    .dbg_idx(dbg_idx), .dbg_data(dbg_data), .stall(stall), .id_ex(id_ex)
  );

  execute_stage u_execute (
    .clk(clk), .reset(reset), .id_ex(id_ex), .wb(wb),
    .redirect(redirect), .redirect_pc(redirect_pc), .halt_seen(halt_seen), .ex_mem(ex_mem)
  );

  memory_stage u_memory (
    .clk(clk), .reset(reset), .ex_mem(ex_mem), .wb(wb)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (wb.halt) begin
      is_halted <= 1'b1;  // rises as the ecall leaves mem/wb
    end
  end

endmodule

/* tests/cpu_sva.sv */
// bound into cpu; halt must clear on reset, stay sticky, and block every later register write
`timescale 1ns/1ns

module cpu_sva (
  input logic         clk,
  input logic         reset,
  input logic         is_halted,
  input cpu_pkg::wb_t wb
);

  a_halt_clear: assert property (@(posedge clk) reset |=> !is_halted)
    else $error("is_halted still high in the cycle after reset");

  // only reset may drop the flag
  a_halt_sticky: assert property (@(posedge clk) (is_halted && !reset) |=> is_halted)
    else $error("is_halted fell without reset");

  a_no_commit: assert property (@(posedge clk) disable iff (reset) is_halted |-> !wb.reg_write)
    else $error("register write committed after halt");

endmodule

bind cpu cpu_sva u_cpu_sva (
  .clk(clk), .reset(reset), .is_halted(is_halted), .wb(wb)
);

/* tests/cpu_tb.sv */
// random forward-only programs that end in a halting ecall; each test reloads all of imem
`timescale 1ns/1ns

module cpu_tb;

  localparam int num_tests = 25;
  localparam int max_insts = 48;  // body plus the halt pair
  localparam int clk_period = 20;
  localparam int test_cycles = max_insts * 4 + 50;  // run budget per test
  localparam int overhead_cycles = cpu_pkg::imem_depth + 8 + 4 + 32 + 2;  // load, reset, reads

  logic clk;
  logic reset;
  logic prog_we;
  logic [cpu_pkg::imem_addr_w-1:0] prog_addr;
  logic [cpu_pkg::xlen-1:0] prog_data;
  logic [cpu_pkg::reg_idx_w-1:0] dbg_idx;
  logic is_halted;
  logic [cpu_pkg::xlen-1:0] dbg_data;

  logic [31:0] prog [cpu_pkg::imem_depth];
  logic [31:0] model_rf [32];
  logic [31:0] model_mem [cpu_pkg::dmem_depth];
  int passed;
  int failed;

  cpu u_cpu (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .dbg_idx(dbg_idx), .is_halted(is_halted), .dbg_data(dbg_data)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::opc_store};  // sw
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::opc_jal};
  endfunction

  // x0..x8 plus x17, small pool so hazards show up often
  function automatic logic [4:0] pick_reg();
    int r;
    r = $urandom % 10;
    return (r == 9) ? 5'd17 : r[4:0];
  endfunction

  task automatic gen_program(output int n);
    logic [2:0] alu_f3 [6];
    int kind;
    int sel;
    int off;
    alu_f3 = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};  // add sub and or xor slt
    n = 20 + $urandom % (max_insts - 21);  // 20..46
    for (int i = 0; i < cpu_pkg::imem_depth; i++) begin
      prog[i] = enc_i(i[11:0], 5'd0, 3'd0, 5'(i % 31 + 1), cpu_pkg::opc_op_imm);  // trap fill
    end
    for (int i = 0; i < n; i++) begin
      kind = $urandom % 10;
      sel = $urandom % 6;
      off = 1 + $urandom % ((n - i < 4) ? n - i : 4);  // never past the halt pair
      case (kind)
        0, 1: prog[i] = enc_r(alu_f3[sel], (sel == 1) ? 7'h20 : 7'h00,
                              pick_reg(), pick_reg(), pick_reg());
        2, 3: prog[i] = enc_i(12'($urandom), pick_reg(), 3'd0, pick_reg(), cpu_pkg::opc_op_imm);
        4: prog[i] = enc_i(12'(4 * ($urandom % 16)), 5'd0, 3'b010, pick_reg(), cpu_pkg::opc_load);
        5: prog[i] = enc_s(12'(4 * ($urandom % 16)), pick_reg(), 5'd0);
        6: prog[i] = enc_b(13'(off * 4), pick_reg(), pick_reg(), {2'b00, sel[0]});  // beq/bne
        7: prog[i] = enc_j(21'(off * 4), pick_reg());
        8: prog[i] = 32'h0000_0073;  // ecall, halts only if x17 is 10
        default: prog[i] = enc_i(12'($urandom % 10), 5'd0, 3'd0, 5'd17, cpu_pkg::opc_op_imm);
      endcase
    end
    prog[n] = enc_i(12'd10, 5'd0, 3'd0, 5'd17, cpu_pkg::opc_op_imm);  // x17 = 10
    prog[n + 1] = 32'h0000_0073;
  endtask

  // isa-level interpreter, one instruction per step
  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] immi;
    bit halted;
    int steps;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    for (int i = 0; i < cpu_pkg::dmem_depth; i++) model_mem[i] = '0;
    pc = cpu_pkg::reset_pc;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < 4 * max_insts) begin
      w = prog[pc[7:2]];
      a = model_rf[w[19:15]];
      b = model_rf[w[24:20]];
      immi = {{20{w[31]}}, w[31:20]};
      next_pc = pc + 4;
      case (w[6:0])
        cpu_pkg::opc_op: begin
          case (w[14:12])
            3'd0: model_rf[w[11:7]] = w[30] ? a - b : a + b;
            3'd7: model_rf[w[11:7]] = a & b;
            3'd6: model_rf[w[11:7]] = a | b;
            3'd4: model_rf[w[11:7]] = a ^ b;
            3'd2: model_rf[w[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        cpu_pkg::opc_op_imm: model_rf[w[11:7]] = a + immi;
        cpu_pkg::opc_load: begin
          addr = a + immi;
          model_rf[w[11:7]] = model_mem[addr[7:2]];
        end
        cpu_pkg::opc_store: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          model_mem[addr[7:2]] = b;
        end
        cpu_pkg::opc_branch: begin
          if ((w[14:12] == 3'd0) ? (a == b) : (a != b)) begin
            next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        cpu_pkg::opc_jal: begin
          model_rf[w[11:7]] = pc + 4;  // link
          next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        cpu_pkg::opc_system: halted = (model_rf[17] == 32'd10);
        default: ;
      endcase
      model_rf[0] = '0;
      pc = next_pc;
      steps++;
    end
  endtask

  task automatic run_test(input int t);
    string name;
    int n;
    int cycles;
    int errs;
    name = $sformatf("prog_%0d", t);
    errs = 0;
    gen_program(n);
    run_model();
    for (int i = 0; i < cpu_pkg::imem_depth; i++) begin
      prog_we = 1'b1;
      prog_addr = i[cpu_pkg::imem_addr_w-1:0];
      prog_data = prog[i];
      @(posedge clk);
      #2;
    end
    prog_we = 1'b0;
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    cycles = 0;
    while (!is_halted && cycles < test_cycles) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!is_halted) begin
      $display("%s: core never raised is_halted within %0d cycles", name, test_cycles);
      errs++;
    end
    repeat (4) @(posedge clk);  // late commits would land here
    #2;
    for (int r = 0; r < 32; r++) begin
      dbg_idx = r[4:0];
      #(clk_period / 2);  // mid cycle
      if (dbg_data !== model_rf[r]) begin
        $display("mismatch %s x%0d expected %08h actual %08h", name, r, model_rf[r], dbg_data);
        errs++;
      end
      @(posedge clk);
      #2;
    end
    if (errs == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("%s %s: %0d body instructions, halted after %0d cycles, %0d errors",
             name, (errs == 0) ? "ok" : "bad", n, cycles, errs);
  endtask

  initial begin
    void'($urandom(32'ha1029476));
    clk = 1'b0;
    reset = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_idx = '0;
    passed = 0;
    failed = 0;
    @(posedge clk);
    #2;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d passed, %0d failed", num_tests, passed, failed);
    if (failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(num_tests * (test_cycles + overhead_cycles) * clk_period);
    $display("watchdog expired before all tests finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* cpu.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/memory_stage.sv
      - src/cpu.sv
  - target: test
    files:
      - tests/cpu_sva.sv
      - tests/cpu_tb.sv
